// File: include/l1_agc_defs.svh
`ifndef L1_AGC_DEFS_SVH
`define L1_AGC_DEFS_SVH

// sample path widths
`define L1_SAMPLE_W     12      // signed adc sample
`define L1_SCALED_W     8       // signed, after gain and saturation
`define L1_SCALE_W      12      // unsigned scale, fraction of 4096
`define L1_SCALE_FRAC   12      // fractional bits of scale
`define L1_POWER_W      15      // square of a scaled sample

// measurement window
`define L1_WINDOW_BITS  8       // 256 valid samples per window
`define L1_SQSUM_W      23      // power sum over one window
`define L1_CNT_W        9       // sign counters, up to 256

// gain loop
`define L1_SCALE_RESET  1024    // scale out of reset
`define L1_SCALE_STEP   8       // scale change per window
`define L1_SCALE_MIN    1
`define L1_SCALE_MAX    4095

// power band around 1024 per sample * 256 samples
`define L1_SQSUM_HI     278528
`define L1_SQSUM_LO     245760

`define L1_OFFSET_SHIFT 3       // offset correction = (pos - neg) >>> 3

`endif

// File: logic/l1_agc_pkg.sv
`include "l1_agc_defs.svh"

package l1_agc_pkg;

    // raw adc sample with its strobe
    typedef struct packed {
        logic                           valid;
        logic signed [`L1_SAMPLE_W-1:0] data;
    } l1_sample_t;                                  // 13 bits

    // sample after offset, scale and saturation
    typedef struct packed {
        logic                           valid;
        logic signed [`L1_SCALED_W-1:0] data;
    } l1_scaled_t;                                  // 9 bits

    typedef struct packed {
        logic                    valid;
        logic [`L1_POWER_W-1:0]  power;             // scaled^2
        logic                    pos;               // scaled > 0
        logic                    neg;               // scaled < 0
    } l1_power_t;                                   // 18 bits

    // gain applied by the front stage
    typedef struct packed {
        logic [`L1_SCALE_W-1:0]         scale;      // x/4096
        logic signed [`L1_SAMPLE_W-1:0] offset;     // added before scaling
    } agc_gain_t;                                   // 24 bits

    // one window worth of statistics
    typedef struct packed {
        logic                    valid;
        logic [`L1_SQSUM_W-1:0]  sq_sum;
        logic [`L1_CNT_W-1:0]    pos_cnt;
        logic [`L1_CNT_W-1:0]    neg_cnt;
    } agc_meas_t;                                   // 42 bits

endpackage

// File: logic/agc_gain_stage.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module agc_gain_stage import l1_agc_pkg::*; (
    input  logic       wbclk,
    input  logic       rst_i,
    input  l1_sample_t sample_i,
    input  agc_gain_t  gain_i,
    output l1_scaled_t scaled_o
);

    localparam int SUM_W  = `L1_SAMPLE_W + 1;            // sample plus offset never overflows
    localparam int PROD_W = SUM_W + `L1_SCALE_W + 1;     // signed x zero-extended scale

    // saturation bounds of the scaled output at product width
    localparam logic signed [PROD_W-1:0] SAT_HI = PROD_W'(2 ** (`L1_SCALED_W - 1) - 1);
    localparam logic signed [PROD_W-1:0] SAT_LO = PROD_W'(-(2 ** (`L1_SCALED_W - 1)));

    logic signed [SUM_W-1:0]        sum;
    logic signed [PROD_W-1:0]       prod;
    logic signed [PROD_W-1:0]       shifted;
    logic signed [`L1_SCALED_W-1:0] sat;

    assign sum  = SUM_W'(sample_i.data) + SUM_W'(gain_i.offset);
    // unsigned scale stays positive in the signed multiply
    assign prod = PROD_W'(sum) * PROD_W'($signed({1'b0, gain_i.scale}));
    assign shifted = prod >>> `L1_SCALE_FRAC;            // drop fraction with floor toward -inf

    always_comb begin
        if (shifted > SAT_HI) begin
            sat = {1'b0, {(`L1_SCALED_W-1){1'b1}}};      // +127
        end else if (shifted < SAT_LO) begin
            sat = {1'b1, {(`L1_SCALED_W-1){1'b0}}};      // -128
        end else begin
            sat = shifted[`L1_SCALED_W-1:0];
        end
    end

    // one register stage using the gain of the input cycle
    always_ff @(posedge wbclk) begin
        if (rst_i) begin
            scaled_o.valid <= 1'b0;
        end else begin
            scaled_o.valid <= sample_i.valid;
        end
        scaled_o.data <= sat;                            // payload qualified by valid
    end

    // a zero scale from the loop controller would kill the channel
    assert property (@(posedge wbclk) disable iff (rst_i)
        sample_i.valid |-> (gain_i.scale != '0))
        else $error("gain stage: zero scale on a valid sample");

endmodule

// File: logic/sample_power_stage.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module sample_power_stage import l1_agc_pkg::*; (
    input  logic                   wbclk,
    input  logic                   rst_i,
    input  l1_scaled_t             scaled_i,
    input  logic [`L1_POWER_W-1:0] threshold_i,
    output l1_power_t              power_o,
    output logic                   trigger_o
);

    logic signed [`L1_POWER_W-1:0] ext;     // sign-extended scaled value
    logic [`L1_POWER_W-1:0]        sq;

    assign ext = `L1_POWER_W'(scaled_i.data);
    assign sq  = ext * ext;                 // max 128^2 = 16384, fits 15 bits

    always_ff @(posedge wbclk) begin
        if (rst_i) begin
            power_o.valid <= 1'b0;
            trigger_o     <= 1'b0;
        end else begin
            power_o.valid <= scaled_i.valid;
            // strictly above threshold, only on a real sample
            trigger_o     <= scaled_i.valid && (sq > threshold_i);
        end
        power_o.power <= sq;
        power_o.pos   <= (scaled_i.data > 0);
        power_o.neg   <= (scaled_i.data < 0);
    end

    // trigger and power leave together, downstream pairs them by cycle
    assert property (@(posedge wbclk) disable iff (rst_i)
        trigger_o |-> power_o.valid)
        else $error("power stage: trigger without valid power");

endmodule

// File: logic/agc_window_meter.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module agc_window_meter import l1_agc_pkg::*; (
    input  logic      wbclk,
    input  logic      rst_i,
    input  l1_power_t power_i,
    output agc_meas_t meas_o
);

    localparam int WIN = 2 ** `L1_WINDOW_BITS;

    logic [`L1_WINDOW_BITS-1:0] item_cnt;      // valid items seen this window
    logic [`L1_SQSUM_W-1:0]     sq_acc;
    logic [`L1_CNT_W-1:0]       pos_acc;
    logic [`L1_CNT_W-1:0]       neg_acc;

    logic [`L1_SQSUM_W-1:0] sq_nx;
    logic [`L1_CNT_W-1:0]   pos_nx;
    logic [`L1_CNT_W-1:0]   neg_nx;
    logic                   last;

    // running sums including the current item
    assign sq_nx  = sq_acc + `L1_SQSUM_W'(power_i.power);
    assign pos_nx = pos_acc + `L1_CNT_W'(power_i.pos);
    assign neg_nx = neg_acc + `L1_CNT_W'(power_i.neg);

    assign last = power_i.valid && (&item_cnt);    // 256th item

    always_ff @(posedge wbclk) begin
        if (rst_i) begin
            item_cnt     <= '0;
            sq_acc       <= '0;
            pos_acc      <= '0;
            neg_acc      <= '0;
            meas_o.valid <= 1'b0;
        end else begin
            meas_o.valid <= last;
            if (power_i.valid) begin
                item_cnt <= item_cnt + 1'b1;       // wraps to 0 after the last item
                if (last) begin
                    // new window starts empty
                    sq_acc  <= '0;
                    pos_acc <= '0;
                    neg_acc <= '0;
                end else begin
                    sq_acc  <= sq_nx;
                    pos_acc <= pos_nx;
                    neg_acc <= neg_nx;
                end
            end
        end
        if (last) begin
            meas_o.sq_sum  <= sq_nx;               // final sums incl. last item
            meas_o.pos_cnt <= pos_nx;
            meas_o.neg_cnt <= neg_nx;
        end
    end

    // a sample is at most one of pos/neg, so a window cannot count more than its length
    assert property (@(posedge wbclk) disable iff (rst_i)
        meas_o.valid |->
            (({1'b0, meas_o.pos_cnt} + {1'b0, meas_o.neg_cnt}) <= (`L1_CNT_W+1)'(WIN)))
        else $error("window meter: sign counts exceed window length");

endmodule

// File: logic/agc_loop_ctrl.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module agc_loop_ctrl import l1_agc_pkg::*; (
    input  logic      wbclk,
    input  logic      rst_i,
    input  agc_meas_t meas_i,
    input  logic      loop_en_i,
    input  logic      cfg_load_i,
    input  agc_gain_t cfg_gain_i,
    output agc_gain_t gain_o
);

    localparam int SC_W   = `L1_SCALE_W + 2;       // signed, room for +-step
    localparam int OF_W   = `L1_SAMPLE_W + 1;      // signed, room for correction
    localparam int DIFF_W = `L1_CNT_W + 1;         // pos - neg, -256..256

    localparam logic signed [OF_W-1:0] OFF_HI = OF_W'(2 ** (`L1_SAMPLE_W - 1) - 1);
    localparam logic signed [OF_W-1:0] OFF_LO = OF_W'(-(2 ** (`L1_SAMPLE_W - 1)));

    logic signed [SC_W-1:0]         scale_step;
    logic signed [SC_W-1:0]         scale_raw;
    logic [`L1_SCALE_W-1:0]         scale_nx;
    logic signed [DIFF_W-1:0]       sign_diff;
    logic signed [DIFF_W-1:0]       off_corr;
    logic signed [OF_W-1:0]         off_raw;
    logic signed [`L1_SAMPLE_W-1:0] off_nx;
    logic                           loop_upd;

    assign loop_upd = meas_i.valid && loop_en_i;

    // scale steps down when loud and up when quiet, holds inside the band
    always_comb begin
        scale_step = '0;
        if (meas_i.sq_sum > `L1_SQSUM_W'(`L1_SQSUM_HI)) begin
            scale_step = -SC_W'(`L1_SCALE_STEP);
        end else if (meas_i.sq_sum < `L1_SQSUM_W'(`L1_SQSUM_LO)) begin
            scale_step = SC_W'(`L1_SCALE_STEP);
        end
        scale_raw = SC_W'($signed({1'b0, gain_o.scale})) + scale_step;
        if (scale_raw < SC_W'(`L1_SCALE_MIN)) begin
            scale_nx = `L1_SCALE_W'(`L1_SCALE_MIN);        // never reach zero gain
        end else if (scale_raw > SC_W'(`L1_SCALE_MAX)) begin
            scale_nx = `L1_SCALE_W'(`L1_SCALE_MAX);
        end else begin
            scale_nx = scale_raw[`L1_SCALE_W-1:0];
        end
    end

    // offset pushes against the sign imbalance of the window
    always_comb begin
        sign_diff = $signed({1'b0, meas_i.pos_cnt}) - $signed({1'b0, meas_i.neg_cnt});
        off_corr  = sign_diff >>> `L1_OFFSET_SHIFT;
        off_raw   = OF_W'(gain_o.offset) - OF_W'(off_corr);
        if (off_raw > OFF_HI) begin
            off_nx = {1'b0, {(`L1_SAMPLE_W-1){1'b1}}};
        end else if (off_raw < OFF_LO) begin
            off_nx = {1'b1, {(`L1_SAMPLE_W-1){1'b0}}};
        end else begin
            off_nx = off_raw[`L1_SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge wbclk) begin
        if (rst_i) begin
            gain_o.scale  <= `L1_SCALE_W'(`L1_SCALE_RESET);
            gain_o.offset <= '0;
        end else if (cfg_load_i) begin
            gain_o <= cfg_gain_i;                  // load beats a loop update
        end else if (loop_upd) begin
            gain_o.scale  <= scale_nx;
            gain_o.offset <= off_nx;
        end
    end

    // gain stage needs a usable scale whether loaded or stepped
    assert property (@(posedge wbclk) disable iff (rst_i)
        gain_o.scale != '0)
        else $error("loop ctrl: scale left the range 1..4095");

endmodule

// File: logic/l1_agc_top.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module l1_agc_top import l1_agc_pkg::*; (
    input  logic                   wbclk,
    input  logic                   rst_i,
    input  l1_sample_t             sample_i,
    input  logic [`L1_POWER_W-1:0] threshold_i,
    input  logic                   loop_en_i,
    input  logic                   cfg_load_i,
    input  agc_gain_t              cfg_gain_i,
    output l1_scaled_t             scaled_o,
    output l1_power_t              power_o,
    output logic                   trigger_o,
    output agc_meas_t              meas_o,
    output agc_gain_t              gain_o
);

    // sample -> gain -> power/trigger -> window -> loop, gain_o fed back
    agc_gain_stage u_gain (
        .wbclk    (wbclk),
        .rst_i    (rst_i),
        .sample_i (sample_i),
        .gain_i   (gain_o),             // feedback from the loop
        .scaled_o (scaled_o)
    );

    sample_power_stage u_power (
        .wbclk       (wbclk),
        .rst_i       (rst_i),
        .scaled_i    (scaled_o),
        .threshold_i (threshold_i),
        .power_o     (power_o),
        .trigger_o   (trigger_o)
    );

    agc_window_meter u_meter (
        .wbclk   (wbclk),
        .rst_i   (rst_i),
        .power_i (power_o),
        .meas_o  (meas_o)
    );

    agc_loop_ctrl u_loop (
        .wbclk      (wbclk),
        .rst_i      (rst_i),
        .meas_i     (meas_o),
        .loop_en_i  (loop_en_i),
        .cfg_load_i (cfg_load_i),
        .cfg_gain_i (cfg_gain_i),
        .gain_o     (gain_o)
    );

endmodule

// File: sim/agc_checker.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module agc_checker import l1_agc_pkg::*; (
    input  logic                   wbclk,
    input  logic                   rst_i,
    input  l1_sample_t             sample_i,
    input  logic [`L1_POWER_W-1:0] threshold_i,
    input  logic                   loop_en_i,
    input  logic                   cfg_load_i,
    input  agc_gain_t              cfg_gain_i,
    input  l1_scaled_t             scaled_o,
    input  l1_power_t              power_o,
    input  logic                   trigger_o,
    input  agc_meas_t              meas_o,
    input  agc_gain_t              gain_o,
    input  int                     phase,       // 0 before the first test
    output int                     err_cnt,
    output int                     check_cnt
);

    // model state, each is what the dut output should show right now
    l1_scaled_t m_scaled;
    l1_power_t  m_power;
    logic       m_trig;
    agc_meas_t  m_meas;
    agc_gain_t  m_gain;
    int win_cnt, win_sq, win_pos, win_neg;      // open window sums
    int last_phase, test_err, test_chk, test_meas, collisions;

    initial begin
        err_cnt    = 0;
        check_cnt  = 0;
        last_phase = 0;
        collisions = 0;
    end

    // (sample + offset) * scale / 4096, floor, then clamp to 8 bits
    function automatic int scale_ref(input int smp, input int off, input int scl);
        int v;
        v = ((smp + off) * scl) >>> `L1_SCALE_FRAC;
        if (v > 127) return 127;
        if (v < -128) return -128;
        return v;
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        check_cnt++;
        test_chk++;
        if (exp != act) begin
            $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
            err_cnt++;
            test_err++;
        end
    endtask

    function automatic string test_name(input int idx);
        case (idx)
            1: return "fixed gain";
            2: return "saturation";
            3: return "trigger";
            4: return "window measurement";
            5: return "loop update";
            default: return "load priority";
        endcase
    endfunction

    task automatic finish_test(input int idx);
        if (idx >= 4 && test_meas == 0) begin
            $display("test %0d: no measurement strobe was seen", idx);
            err_cnt++;
            test_err++;
        end
        if (idx == 6 && collisions == 0) begin
            $display("test 6: cfg_load_i never came with a measurement strobe");
            err_cnt++;
            test_err++;
        end
        $display("test %0d %s: %0d checks, %0d errors", idx, test_name(idx), test_chk, test_err);
    endtask

    always @(posedge wbclk) begin
        int p;
        int sc;
        int off;
        if (phase != last_phase) begin
            if (last_phase >= 1 && last_phase <= 6) finish_test(last_phase);
            last_phase = phase;
            test_err   = 0;
            test_chk   = 0;
            test_meas  = 0;
        end
        if (rst_i) begin
            m_scaled.valid = 1'b0;
            m_power.valid  = 1'b0;
            m_trig         = 1'b0;
            m_meas.valid   = 1'b0;
            m_gain.scale   = `L1_SCALE_W'(`L1_SCALE_RESET);
            m_gain.offset  = '0;
            win_cnt = 0;
            win_sq  = 0;
            win_pos = 0;
            win_neg = 0;
        end else begin
            check_val("scaled_o.valid", m_scaled.valid, scaled_o.valid);
            if (m_scaled.valid) check_val("scaled_o.data", m_scaled.data, scaled_o.data);
            check_val("power_o.valid", m_power.valid, power_o.valid);
            if (m_power.valid) begin                // payload only matters with valid
                check_val("power_o.power", m_power.power, power_o.power);
                check_val("power_o.pos", m_power.pos, power_o.pos);
                check_val("power_o.neg", m_power.neg, power_o.neg);
            end
            check_val("trigger_o", m_trig, trigger_o);
            check_val("meas_o.valid", m_meas.valid, meas_o.valid);
            if (m_meas.valid) begin
                test_meas++;
                check_val("meas_o.sq_sum", m_meas.sq_sum, meas_o.sq_sum);
                check_val("meas_o.pos_cnt", m_meas.pos_cnt, meas_o.pos_cnt);
                check_val("meas_o.neg_cnt", m_meas.neg_cnt, meas_o.neg_cnt);
            end
            check_val("gain_o.scale", m_gain.scale, gain_o.scale);
            check_val("gain_o.offset", m_gain.offset, gain_o.offset);

            // gain register, a load beats the loop
            if (phase == 6 && m_meas.valid && cfg_load_i) collisions++;
            if (cfg_load_i) begin
                m_gain = cfg_gain_i;
            end else if (m_meas.valid && loop_en_i) begin
                sc = m_gain.scale;
                if (m_meas.sq_sum > `L1_SQSUM_HI) sc -= `L1_SCALE_STEP;       // too loud
                else if (m_meas.sq_sum < `L1_SQSUM_LO) sc += `L1_SCALE_STEP;  // too quiet
                sc  = (sc < 1) ? 1 : (sc > 4095) ? 4095 : sc;
                off = (int'(m_meas.pos_cnt) - int'(m_meas.neg_cnt)) >>> `L1_OFFSET_SHIFT;
                off = m_gain.offset - off;
                off = (off < -2048) ? -2048 : (off > 2047) ? 2047 : off;
                m_gain.scale  = `L1_SCALE_W'(sc);
                m_gain.offset = `L1_SAMPLE_W'(off);
            end

            // window sums, strobe includes the 256th item
            m_meas.valid = 1'b0;
            if (m_power.valid) begin
                win_cnt++;
                win_sq  += m_power.power;
                win_pos += m_power.pos;
                win_neg += m_power.neg;
                if (win_cnt == (1 << `L1_WINDOW_BITS)) begin
                    m_meas.valid   = 1'b1;
                    m_meas.sq_sum  = `L1_SQSUM_W'(win_sq);
                    m_meas.pos_cnt = `L1_CNT_W'(win_pos);
                    m_meas.neg_cnt = `L1_CNT_W'(win_neg);
                    win_cnt = 0;
                    win_sq  = 0;
                    win_pos = 0;
                    win_neg = 0;
                end
            end

            p = int'(m_scaled.data) * int'(m_scaled.data);
            m_trig        = m_scaled.valid && (p > int'(threshold_i));   // strictly above
            m_power.valid = m_scaled.valid;
            m_power.power = `L1_POWER_W'(p);
            m_power.pos   = (m_scaled.data > 0);
            m_power.neg   = (m_scaled.data < 0);

            // gain as the dut shows it in the input cycle
            m_scaled.valid = sample_i.valid;
            m_scaled.data  = `L1_SCALED_W'(scale_ref(sample_i.data, gain_o.offset, gain_o.scale));
        end
    end

endmodule

// File: sim/tb_l1_agc.sv
`timescale 1ns/10ps
`include "l1_agc_defs.svh"

module tb_l1_agc import l1_agc_pkg::*; ();

    localparam int PHASE_LEN = 2000;                    // cycles per test
    localparam int TIMEOUT   = PHASE_LEN * 6 * 3 / 2;   // six tests with 1.5x margin

    logic                   wbclk;
    logic                   rst_i;
    l1_sample_t             sample_i;
    logic [`L1_POWER_W-1:0] threshold_i;
    logic                   loop_en_i;
    logic                   cfg_load_i;
    agc_gain_t              cfg_gain_i;
    l1_scaled_t             scaled_o;
    l1_power_t              power_o;
    logic                   trigger_o;
    agc_meas_t              meas_o;
    agc_gain_t              gain_o;

    int seed = 36;
    int cycles = 0;
    int phase;                                  // test number seen by the checker
    int err_cnt;
    int check_cnt;

    l1_agc_top dut (.*);
    agc_checker chk (.*);

    always #50 wbclk = ~wbclk;                  // 100 ns period

    always @(posedge wbclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic bit chance(input int pct);
        return rand_range(0, 99) < pct;
    endfunction

    // one-cycle cfg_load_i pulse
    task automatic load_gain(input int scale, input int offset);
        @(posedge wbclk);
        cfg_gain_i.scale  <= `L1_SCALE_W'(scale);
        cfg_gain_i.offset <= `L1_SAMPLE_W'(offset);
        cfg_load_i        <= 1'b1;
        @(posedge wbclk);
        cfg_load_i        <= 1'b0;
    endtask

    task automatic drive_cycles(input int n, input int valid_pct, input int lo, input int hi,
                                input int load_pct);
        repeat (n) begin
            @(posedge wbclk);
            sample_i.valid    <= chance(valid_pct);
            sample_i.data     <= `L1_SAMPLE_W'(rand_range(lo, hi));
            threshold_i       <= `L1_POWER_W'(rand_range(0, 17000));   // some above 128^2
            cfg_load_i        <= chance(load_pct);
            cfg_gain_i.scale  <= `L1_SCALE_W'(rand_range(1, 4095));    // never zero
            cfg_gain_i.offset <= `L1_SAMPLE_W'(rand_range(-2048, 2047));
        end
    endtask

    initial begin
        wbclk       = 1'b0;
        rst_i       = 1'b1;
        sample_i    = '0;
        threshold_i = '0;
        loop_en_i   = 1'b0;
        cfg_load_i  = 1'b0;
        cfg_gain_i  = '0;
        phase       = 0;
        repeat (2) @(posedge wbclk);
        rst_i <= 1'b0;
        phase <= 1;                                 // loop off with gaps in valid
        load_gain(rand_range(256, 1024), rand_range(-128, 127));
        drive_cycles(PHASE_LEN, 70, -512, 511, 0);
        phase <= 2;                                 // full scale clamps both ways
        load_gain(4095, 0);
        drive_cycles(PHASE_LEN, 80, -2048, 2047, 0);
        phase <= 3;
        load_gain(1024, 0);
        drive_cycles(PHASE_LEN, 50, -600, 600, 0);
        phase <= 4;                                 // back to back samples
        load_gain(768, 0);
        drive_cycles(PHASE_LEN, 100, -800, 800, 0);
        phase     <= 5;
        loop_en_i <= 1'b1;
        load_gain(1024, 0);
        drive_cycles(700, 100, -2048, 2047, 0);     // loud so scale steps down
        drive_cycles(1300, 100, 40, 160, 0);        // quiet and positive so offset pulls down
        phase <= 6;                                 // frequent loads against strobes
        drive_cycles(PHASE_LEN, 100, -1024, 1023, 75);
        @(posedge wbclk);
        phase          <= 7;                        // closes test 6
        sample_i.valid <= 1'b0;
        cfg_load_i     <= 1'b0;
        repeat (4) @(posedge wbclk);
        @(negedge wbclk);                           // counts settled after the last compare
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0 && check_cnt > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
logic/l1_agc_pkg.sv
logic/agc_gain_stage.sv
logic/sample_power_stage.sv
logic/agc_window_meter.sv
logic/agc_loop_ctrl.sv
logic/l1_agc_top.sv
sim/agc_checker.sv
sim/tb_l1_agc.sv

// File: Makefile
TOP = tb_l1_agc

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
